// ==== source/core_cfg_pkg.sv ====
// Core configuration package
// Datapath, program counter and memory widths with their vector types
`default_nettype none

package core_cfg_pkg;

    localparam int XLEN = 32;                      // Integer register width
    typedef logic [XLEN-1:0] xlen_t;

    typedef logic [XLEN-1:0] pc_t;                 // Byte address
    localparam pc_t PC_STEP = 32'd4;               // One word per instruction

    // 64-word instruction memory
    localparam int IMEM_ADDR_WIDTH = 6;
    typedef logic [IMEM_ADDR_WIDTH-1:0] imem_addr_t;

    localparam int REG_ADDR_WIDTH = 5;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    localparam int NUM_REGS = 32;                  // x0 to x31

endpackage

`default_nettype wire

// ==== source/rv_isa_pkg.sv ====
// RV32I encoding package
// Instruction type, kept opcodes, funct3/funct7 codes and the ALU operation enum
`default_nettype none

package rv_isa_pkg;

    localparam int ILEN = 32;
    typedef logic [ILEN-1:0] instr_t;

    // Register-register and register-immediate ALU groups
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    localparam logic [2:0] F3_ADD  = 3'b000;       // ADD, SUB, ADDI
    localparam logic [2:0] F3_SLL  = 3'b001;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_SLTU = 3'b011;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_SR   = 3'b101;       // SRL and SRA
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;

    // Alternate encoding, bit 30 of the instruction
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

endpackage

`default_nettype wire

// ==== source/decode_bus_if.sv ====
// ID/EX pipeline bus
// Decoded control, operands and register addresses from decode to execute
`timescale 1ns/1ns
`default_nettype none

interface decode_bus_if;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic      reg_write;                          // Low marks a bubble
    alu_op_e   alu_op;
    logic      use_imm;                            // Operand B from imm
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    xlen_t     imm;
    reg_addr_t rs1_addr;                           // Kept for forwarding
    reg_addr_t rs2_addr;
    reg_addr_t rd_addr;

    modport decode (output reg_write, alu_op, use_imm, rs1_data, rs2_data, imm,
                    rs1_addr, rs2_addr, rd_addr);
    modport execute (input reg_write, alu_op, use_imm, rs1_data, rs2_data, imm,
                     rs1_addr, rs2_addr, rd_addr);

endinterface

`default_nettype wire

// ==== source/fetch_unit.sv ====
// Instruction fetch stage
// Run enable, program counter, instruction memory with its load port,
// IF/ID register and the registered PC and instruction outputs
`timescale 1ns/1ns
`default_nettype none

module fetch_unit (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  logic                     i_imem_wen,
    input  core_cfg_pkg::imem_addr_t i_imem_waddr,
    input  rv_isa_pkg::instr_t       i_imem_data,
    output logic                     o_run,
    output rv_isa_pkg::instr_t       o_ifid_instr,
    output core_cfg_pkg::pc_t        o_pc,
    output rv_isa_pkg::instr_t       o_instr
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic       imem_wen_q;
    imem_addr_t imem_waddr_q;
    instr_t     imem_data_q;
    pc_t        pc_q;
    instr_t     fetch_word;
    instr_t     imem [2**IMEM_ADDR_WIDTH];

    // Write port is registered once, the word lands on the following edge
    always_ff @(posedge clk) begin
        imem_waddr_q <= i_imem_waddr;
        imem_data_q  <= i_imem_data;
        if (imem_wen_q) begin
            imem[imem_waddr_q] <= imem_data_q;
        end
    end

    assign fetch_word = imem[pc_q[IMEM_ADDR_WIDTH+1:2]];   // Word address of the PC

    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_run        <= 1'b0;
            imem_wen_q   <= 1'b0;
            pc_q         <= '0;
            o_ifid_instr <= '0;                    // Zero word decodes as a bubble
            o_pc         <= '0;
            o_instr      <= '0;
        end else begin
            o_run      <= i_en;
            imem_wen_q <= i_imem_wen;
            if (o_run) begin
                pc_q         <= pc_q + PC_STEP;
                o_ifid_instr <= fetch_word;
            end
            // Observation copies, one cycle behind the fetch
            o_pc    <= pc_q;
            o_instr <= fetch_word;
        end
    end

endmodule

`default_nettype wire

// ==== source/reg_file.sv ====
// Integer register file
// 32 entries with x0 tied to zero, write-to-read bypass on both ports,
// debug address select on port 1 and the registered debug output
`timescale 1ns/1ns
`default_nettype none

module reg_file (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_run,
    input  core_cfg_pkg::reg_addr_t i_rs1_addr,
    input  core_cfg_pkg::reg_addr_t i_rs2_addr,
    input  logic                    i_dbg_rd,
    input  core_cfg_pkg::reg_addr_t i_dbg_addr,
    input  logic                    i_wb_we,
    input  core_cfg_pkg::reg_addr_t i_wb_addr,
    input  core_cfg_pkg::xlen_t     i_wb_data,
    output core_cfg_pkg::xlen_t     o_rs1_data,
    output core_cfg_pkg::xlen_t     o_rs2_data,
    output core_cfg_pkg::xlen_t     o_dbg_data
);
    import core_cfg_pkg::*;

    xlen_t     regs [NUM_REGS];
    logic      wr_en;
    logic      dbg_rd_q;
    reg_addr_t dbg_addr_q;
    reg_addr_t port1_addr;

    assign wr_en      = i_run && i_wb_we && (i_wb_addr != '0);   // x0 never written
    assign port1_addr = dbg_rd_q ? dbg_addr_q : i_rs1_addr;

    always_ff @(posedge clk) begin
        if (i_rst) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb_addr] <= i_wb_data;
        end
    end

    // Same-cycle bypass so decode sees the value being written
    always_comb begin
        o_rs1_data = regs[port1_addr];
        o_rs2_data = regs[i_rs2_addr];
        if (wr_en && (port1_addr == i_wb_addr)) o_rs1_data = i_wb_data;
        if (wr_en && (i_rs2_addr == i_wb_addr)) o_rs2_data = i_wb_data;
    end

    always_ff @(posedge clk) begin
        dbg_addr_q <= i_dbg_addr;
    end

    always_ff @(posedge clk) begin
        if (i_rst) begin
            dbg_rd_q   <= 1'b0;
            o_dbg_data <= '0;
        end else begin
            dbg_rd_q   <= i_dbg_rd;
            o_dbg_data <= o_rs1_data;              // Valid two cycles after the request
        end
    end

endmodule

`default_nettype wire

// ==== source/decode_unit.sv ====
// Instruction decode stage
// Field split, I-type immediate, control and ALU operation decode,
// and the ID/EX register driven onto the decode bus
`timescale 1ns/1ns
`default_nettype none

module decode_unit (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_run,
    input  rv_isa_pkg::instr_t      i_ifid_instr,
    input  core_cfg_pkg::xlen_t     i_rs1_data,
    input  core_cfg_pkg::xlen_t     i_rs2_data,
    output core_cfg_pkg::reg_addr_t o_rs1_addr,
    output core_cfg_pkg::reg_addr_t o_rs2_addr,
    decode_bus_if.decode            o_id_ex
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rd_addr;
    xlen_t      imm;
    logic       dec_we;
    logic       dec_use_imm;
    alu_op_e    dec_op;

    assign opcode     = i_ifid_instr[6:0];
    assign rd_addr    = i_ifid_instr[11:7];
    assign funct3     = i_ifid_instr[14:12];
    assign o_rs1_addr = i_ifid_instr[19:15];
    assign o_rs2_addr = i_ifid_instr[24:20];
    assign funct7     = i_ifid_instr[31:25];   // Also imm[11:5] on OP-IMM

    assign imm = {{(XLEN-12){i_ifid_instr[31]}}, i_ifid_instr[31:20]};

    always_comb begin
        dec_we      = 1'b0;                    // Anything unknown is a bubble
        dec_use_imm = 1'b0;
        if (opcode == OPC_OP) begin
            dec_we = 1'b1;
        end else if (opcode == OPC_OP_IMM) begin
            dec_we      = 1'b1;
            dec_use_imm = 1'b1;
        end

        case (funct3)
            F3_ADD:  dec_op = (opcode == OPC_OP && funct7 == F7_ALT) ? ALU_SUB : ALU_ADD;
            F3_SLL:  dec_op = ALU_SLL;
            F3_SLT:  dec_op = ALU_SLT;
            F3_SLTU: dec_op = ALU_SLTU;
            F3_XOR:  dec_op = ALU_XOR;
            F3_SR:   dec_op = (funct7 == F7_ALT) ? ALU_SRA : ALU_SRL;
            F3_OR:   dec_op = ALU_OR;
            default: dec_op = ALU_AND;
        endcase
    end

    // ID/EX register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_id_ex.reg_write <= 1'b0;
            o_id_ex.use_imm   <= 1'b0;
            o_id_ex.alu_op    <= ALU_ADD;
        end else if (i_run) begin
            o_id_ex.reg_write <= dec_we;
            o_id_ex.use_imm   <= dec_use_imm;
            o_id_ex.alu_op    <= dec_op;
        end
    end

    always_ff @(posedge clk) begin
        if (i_run) begin
            o_id_ex.rs1_data <= i_rs1_data;
            o_id_ex.rs2_data <= i_rs2_data;
            o_id_ex.imm      <= imm;
            o_id_ex.rs1_addr <= o_rs1_addr;
            o_id_ex.rs2_addr <= o_rs2_addr;
            o_id_ex.rd_addr  <= rd_addr;
        end
    end

endmodule

`default_nettype wire

// ==== source/execute_unit.sv ====
// Execute stage
// Forwarding from EX/WB, operand B select, ALU control and ALU,
// and the EX/WB register that feeds write-back
`timescale 1ns/1ns
`default_nettype none

module execute_unit (
    input  logic                    clk,
    input  logic                    i_rst,
    input  logic                    i_run,
    decode_bus_if.execute           i_id_ex,
    output logic                    o_wb_we,
    output core_cfg_pkg::reg_addr_t o_wb_addr,
    output core_cfg_pkg::xlen_t     o_wb_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic       fwd_a;
    logic       fwd_b;
    xlen_t      op_a;
    xlen_t      rs2_val;
    xlen_t      op_b;
    logic [4:0] shamt;
    xlen_t      alu_res;

    // Last result still sitting in EX/WB overrides the stale register read
    assign fwd_a = o_wb_we && (o_wb_addr != '0) && (o_wb_addr == i_id_ex.rs1_addr);
    assign fwd_b = o_wb_we && (o_wb_addr != '0) && (o_wb_addr == i_id_ex.rs2_addr);

    assign op_a    = fwd_a ? o_wb_data : i_id_ex.rs1_data;
    assign rs2_val = fwd_b ? o_wb_data : i_id_ex.rs2_data;
    assign op_b    = i_id_ex.use_imm ? i_id_ex.imm : rs2_val;
    assign shamt   = op_b[4:0];                // RV32I uses the low five bits

    // ALU control and datapath
    always_comb begin
        case (i_id_ex.alu_op)
            ALU_ADD:  alu_res = op_a + op_b;
            ALU_SUB:  alu_res = op_a - op_b;
            ALU_SLL:  alu_res = op_a << shamt;
            ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:  alu_res = op_a ^ op_b;
            ALU_SRL:  alu_res = op_a >> shamt;
            ALU_SRA:  alu_res = xlen_t'($signed(op_a) >>> shamt);
            ALU_OR:   alu_res = op_a | op_b;
            ALU_AND:  alu_res = op_a & op_b;
            default:  alu_res = '0;            // Unused encodings
        endcase
    end

    // EX/WB register
    always_ff @(posedge clk) begin
        if (i_rst) begin
            o_wb_we <= 1'b0;
        end else if (i_run) begin
            o_wb_we <= i_id_ex.reg_write;
        end
    end

    always_ff @(posedge clk) begin
        if (i_run) begin
            o_wb_addr <= i_id_ex.rd_addr;
            o_wb_data <= alu_res;
        end
    end

endmodule

`default_nettype wire

// ==== source/core_top.sv ====
// Core top level
// Four-stage RV32I integer pipeline: fetch, decode, execute and write-back
`timescale 1ns/1ns
`default_nettype none

module core_top (
    input  logic                     clk,
    input  logic                     i_rst,
    input  logic                     i_en,
    input  logic                     i_imem_wen,
    input  core_cfg_pkg::imem_addr_t i_imem_waddr,
    input  rv_isa_pkg::instr_t       i_imem_data,
    input  logic                     i_dbg_rd,
    input  core_cfg_pkg::reg_addr_t  i_regfile_addr,
    output core_cfg_pkg::pc_t        o_pc,
    output rv_isa_pkg::instr_t       o_instr,
    output core_cfg_pkg::xlen_t      o_regfile_data
);
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    logic      run;
    instr_t    ifid_instr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      wb_we;                          // Write-back from EX/WB
    reg_addr_t wb_addr;
    xlen_t     wb_data;

    decode_bus_if id_ex_bus ();

    fetch_unit u_fetch (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_en         (i_en),
        .i_imem_wen   (i_imem_wen),
        .i_imem_waddr (i_imem_waddr),
        .i_imem_data  (i_imem_data),
        .o_run        (run),
        .o_ifid_instr (ifid_instr),
        .o_pc         (o_pc),
        .o_instr      (o_instr)
    );

    decode_unit u_decode (
        .clk          (clk),
        .i_rst        (i_rst),
        .i_run        (run),
        .i_ifid_instr (ifid_instr),
        .i_rs1_data   (rs1_data),
        .i_rs2_data   (rs2_data),
        .o_rs1_addr   (rs1_addr),
        .o_rs2_addr   (rs2_addr),
        .o_id_ex      (id_ex_bus.decode)
    );

    execute_unit u_execute (
        .clk       (clk),
        .i_rst     (i_rst),
        .i_run     (run),
        .i_id_ex   (id_ex_bus.execute),
        .o_wb_we   (wb_we),
        .o_wb_addr (wb_addr),
        .o_wb_data (wb_data)
    );

    reg_file u_reg_file (
        .clk        (clk),
        .i_rst      (i_rst),
        .i_run      (run),
        .i_rs1_addr (rs1_addr),
        .i_rs2_addr (rs2_addr),
        .i_dbg_rd   (i_dbg_rd),
        .i_dbg_addr (i_regfile_addr),
        .i_wb_we    (wb_we),
        .i_wb_addr  (wb_addr),
        .i_wb_data  (wb_data),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .o_dbg_data (o_regfile_data)
    );

endmodule

`default_nettype wire

// ==== verification/core_monitor.sv ====
// Output monitor for the core
// Compares o_pc, o_instr and the debug readout with golden values per test phase
`timescale 1ns/1ns
`default_nettype none

module core_monitor (
    input  wire logic                    clk,
    input  wire logic [2:0]              i_phase,
    input  wire logic                    i_done,
    input  wire core_cfg_pkg::pc_t       i_pc,
    input  wire rv_isa_pkg::instr_t      i_instr,
    input  wire logic                    i_dbg_rd,
    input  wire core_cfg_pkg::reg_addr_t i_dbg_addr,
    input  wire core_cfg_pkg::xlen_t     i_dbg_data,
    input  wire logic [31:0]             i_assert_fails,
    output int                           o_errors
);
    localparam logic [2:0] PH_RESET = 3'd1;
    localparam logic [2:0] PH_RUN   = 3'd3;
    localparam logic [2:0] PH_HOLD  = 3'd4;
    localparam logic [2:0] PH_READ  = 3'd5;
    localparam int PROG_WORDS = 16;
    localparam int RUN_STEPS  = 40;            // One PC step per running edge

    localparam int T_RESET = 0;
    localparam int T_FETCH = 1;
    localparam int T_HOLD  = 2;
    localparam int T_ARITH = 3;
    localparam int T_DEP   = 4;
    localparam int T_ZERO  = 5;

    logic [31:0] golden [48];
    int          checks [6] = '{default: 0};
    int          errs [6] = '{default: 0};
    int          total_errs = 0;
    int          steps = 0;
    logic [2:0]  last_phase = 3'd0;
    logic [31:0] prev_pc;
    logic [31:0] hold_pc;
    logic        summary_done = 1'b0;
    logic        rd_d1;
    logic        rd_d2;
    logic [4:0]  addr_d1;
    logic [4:0]  addr_d2;

    assign o_errors = total_errs + int'(i_assert_fails);

    initial $readmemh("verification/core_golden.hex", golden);

    function automatic string test_name(int t);
        case (t)
            T_RESET: return "reset state";
            T_FETCH: return "fetch";
            T_HOLD:  return "hold";
            T_ARITH: return "arithmetic and immediates";
            T_DEP:   return "dependencies";
            default: return "x0 and untouched registers";
        endcase
    endfunction

    // Registers built from results one to three instructions earlier
    function automatic int reg_test(logic [4:0] idx);
        if (idx == 5'd0 || idx > 5'd15) return T_ZERO;
        if (idx inside {5'd3, 5'd4, 5'd11, 5'd12, 5'd14, 5'd15}) return T_DEP;
        return T_ARITH;
    endfunction

    task automatic check_value(int t, string name, logic [31:0] got, logic [31:0] exp);
        checks[t]++;
        if (got !== exp) begin
            errs[t]++;
            total_errs++;
            $display("MISMATCH at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic report_test(int t);
        $display("Test %-28s %0d checks, %0d errors", test_name(t), checks[t], errs[t]);
    endtask

    task automatic finish_phase(logic [2:0] p);
        if (p == PH_RESET) report_test(T_RESET);
        if (p == PH_RUN) begin
            if (steps != RUN_STEPS) begin
                errs[T_FETCH]++;
                total_errs++;
                $display("Fetch error: PC advanced %0d times, expected %0d",
                         steps, RUN_STEPS);
            end
            report_test(T_FETCH);
        end
        if (p == PH_READ) begin
            for (int t = T_HOLD; t <= T_ZERO; t++) report_test(t);
        end
    endtask

    // Debug data appears two edges after the request
    always @(posedge clk) begin
        rd_d1   <= i_dbg_rd;
        addr_d1 <= i_dbg_addr;
        rd_d2   <= rd_d1;
        addr_d2 <= addr_d1;
    end

    always @(negedge clk) begin
        logic [31:0] exp_instr;
        int          pc_word;
        pc_word = int'(i_pc[31:2]);
        if (i_phase != last_phase) begin
            finish_phase(last_phase);
            if (i_phase == PH_HOLD) hold_pc = i_pc;
            prev_pc    = i_pc;
            last_phase = i_phase;
        end
        case (i_phase)
            PH_RESET: check_value(T_RESET, "o_pc", i_pc, 32'd0);
            PH_RUN: begin
                exp_instr = (pc_word < PROG_WORDS) ? golden[pc_word] : 32'd0;
                check_value(T_FETCH, "o_instr", i_instr, exp_instr);
                if (i_pc != prev_pc) begin         // Each move is one word
                    check_value(T_FETCH, "o_pc", i_pc, prev_pc + 32'd4);
                    steps++;
                end
                prev_pc = i_pc;
            end
            PH_HOLD, PH_READ: check_value(T_HOLD, "o_pc", i_pc, hold_pc);
            default: ;
        endcase
        if (rd_d2) begin
            check_value(reg_test(addr_d2), $sformatf("o_regfile_data x%0d", addr_d2),
                        i_dbg_data, golden[PROG_WORDS + int'(addr_d2)]);
        end
        if (i_done && !summary_done) begin
            summary_done = 1'b1;
            $display("Summary: %0d tests, %0d errors, %0d assertion failures",
                     6, total_errs, i_assert_fails);
        end
    end

endmodule

`default_nettype wire

// ==== verification/core_checker.sv ====
// Register file assertions
// x0 reads as zero on both ports, no write while halted, known debug output
`timescale 1ns/1ns
`default_nettype none

module core_checker (
    input wire logic                    clk,
    input wire logic                    i_rst,
    input wire logic                    i_run,
    input wire core_cfg_pkg::reg_addr_t i_wb_addr,
    input wire core_cfg_pkg::xlen_t     regs [core_cfg_pkg::NUM_REGS],
    input wire core_cfg_pkg::reg_addr_t port1_addr,
    input wire core_cfg_pkg::reg_addr_t i_rs2_addr,
    input wire core_cfg_pkg::xlen_t     o_rs1_data,
    input wire core_cfg_pkg::xlen_t     o_rs2_data,
    input wire core_cfg_pkg::xlen_t     o_dbg_data
);

    int fail_count = 0;                        // Failed assertion count

    a_x0_port1: assert property (@(posedge clk) disable iff (i_rst)
        (port1_addr == '0) |-> (o_rs1_data == '0))
        else begin
            fail_count++;
            $error("x0 read on port 1 returned %h", o_rs1_data);
        end

    a_x0_port2: assert property (@(posedge clk) disable iff (i_rst)
        (i_rs2_addr == '0) |-> (o_rs2_data == '0))
        else begin
            fail_count++;
            $error("x0 read on port 2 returned %h", o_rs2_data);
        end

    // Pipeline frozen means register file frozen
    a_no_write_halted: assert property (@(posedge clk) disable iff (i_rst)
        (!i_run && !$isunknown(i_wb_addr)) |=> $stable(regs[i_wb_addr]))
        else begin
            fail_count++;
            $error("Register write while the core is halted");
        end

    a_dbg_known: assert property (@(posedge clk) disable iff (i_rst)
        !$isunknown(o_dbg_data))
        else begin
            fail_count++;
            $error("Debug output is unknown");
        end

endmodule

bind reg_file core_checker chk_i (.*);

`default_nettype wire

// ==== verification/core_tb.sv ====
// Core testbench
// Clock, reset, program load, run, debug readout, watchdog and final verdict
`timescale 1ns/1ns
`default_nettype none

module core_tb;
    import core_cfg_pkg::*;
    import rv_isa_pkg::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int PROG_WORDS   = 16;
    localparam int IMEM_WORDS   = 64;
    localparam int RUN_CYCLES   = 40;
    localparam int SETTLE       = 3;           // Run and o_pc lag i_en
    localparam int HOLD_CYCLES  = 4;
    localparam int DRAIN        = 4;
    localparam int MARGIN       = 50;
    localparam int TOTAL_CYCLES = RESET_CYCLES + 2 + IMEM_WORDS + 3 + RUN_CYCLES + SETTLE
                                  + HOLD_CYCLES + NUM_REGS + DRAIN + MARGIN;

    localparam logic [2:0] PH_IDLE  = 3'd0;
    localparam logic [2:0] PH_RESET = 3'd1;
    localparam logic [2:0] PH_LOAD  = 3'd2;
    localparam logic [2:0] PH_RUN   = 3'd3;
    localparam logic [2:0] PH_HOLD  = 3'd4;
    localparam logic [2:0] PH_READ  = 3'd5;

    logic       clk = 1'b0;
    logic       i_rst;
    logic       i_en;
    logic       i_imem_wen;
    imem_addr_t i_imem_waddr;
    instr_t     i_imem_data;
    logic       i_dbg_rd;
    reg_addr_t  i_regfile_addr;
    pc_t        o_pc;
    instr_t     o_instr;
    xlen_t      o_regfile_data;
    logic [2:0] phase;
    logic       done;
    int         error_count;
    logic [31:0] golden [48];

    core_top dut_i (
        .clk            (clk),
        .i_rst          (i_rst),
        .i_en           (i_en),
        .i_imem_wen     (i_imem_wen),
        .i_imem_waddr   (i_imem_waddr),
        .i_imem_data    (i_imem_data),
        .i_dbg_rd       (i_dbg_rd),
        .i_regfile_addr (i_regfile_addr),
        .o_pc           (o_pc),
        .o_instr        (o_instr),
        .o_regfile_data (o_regfile_data)
    );

    core_monitor mon_i (
        .clk            (clk),
        .i_phase        (phase),
        .i_done         (done),
        .i_pc           (o_pc),
        .i_instr        (o_instr),
        .i_dbg_rd       (i_dbg_rd),
        .i_dbg_addr     (i_regfile_addr),
        .i_dbg_data     (o_regfile_data),
        .i_assert_fails (dut_i.u_reg_file.chk_i.fail_count),
        .o_errors       (error_count)
    );

    initial begin
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic next_cycle(int n);
        repeat (n) @(posedge clk);
        #1;                                    // Inputs change just after the edge
    endtask

    // Program words first, the rest of the memory cleared to bubbles
    task automatic load_program();
        for (int w = 0; w < IMEM_WORDS; w++) begin
            i_imem_wen   = 1'b1;
            i_imem_waddr = imem_addr_t'(w);
            i_imem_data  = (w < PROG_WORDS) ? golden[w] : 32'd0;
            next_cycle(1);
        end
        i_imem_wen = 1'b0;
        next_cycle(3);
    endtask

    task automatic read_registers();
        for (int r = 0; r < NUM_REGS; r++) begin
            i_dbg_rd       = 1'b1;
            i_regfile_addr = reg_addr_t'(r);
            next_cycle(1);
        end
        i_dbg_rd = 1'b0;
        next_cycle(DRAIN);
    endtask

    initial begin
        i_rst          = 1'b1;
        i_en           = 1'b0;
        i_imem_wen     = 1'b0;
        i_imem_waddr   = '0;
        i_imem_data    = '0;
        i_dbg_rd       = 1'b0;
        i_regfile_addr = '0;
        done           = 1'b0;
        phase          = PH_RESET;
        $readmemh("verification/core_golden.hex", golden);
        next_cycle(RESET_CYCLES);
        i_rst = 1'b0;
        next_cycle(1);
        phase = PH_LOAD;
        load_program();
        phase = PH_RUN;
        i_en  = 1'b1;
        next_cycle(RUN_CYCLES);
        i_en = 1'b0;
        next_cycle(SETTLE);
        phase = PH_HOLD;
        next_cycle(HOLD_CYCLES);
        phase = PH_READ;
        read_registers();
        phase = PH_IDLE;
        done  = 1'b1;
        next_cycle(2);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (TOTAL_CYCLES) @(posedge clk);
        $display("Timeout: the run did not complete within %0d cycles", TOTAL_CYCLES);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/core_golden.hex ====
// Words 0-15 are the program in RV32I encoding, four per line
// Words 16-47 are the expected contents of x0 to x31 after the run
// addi x1,x0,-5   addi x2,x0,12   add x3,x1,x2    sub x4,x3,x1
FFB00093 00C00113 002081B3 40118233
// slt x5,x1,x2    sltu x6,x1,x2   xor x7,x3,x4    sll x8,x2,x3
0020A2B3 0020B333 0041C3B3 00311433
// srl x9,x1,x5    sra x10,x1,x5   or x11,x7,x8    and x12,x11,x1
0050D4B3 4050D533 0083E5B3 0015F633
// sltiu x13,x2,-1 xori x14,x12,-1 srai x15,x14,4  addi x0,x1,7
FFF13693 FFF64713 40475793 00708013
// x0 to x7
00000000 FFFFFFFB 0000000C 00000007 0000000C 00000001 00000000 0000000B
// x8 to x15
00000600 7FFFFFFD FFFFFFFD 0000060B 0000060B 00000001 FFFFF9F4 FFFFFF9F
// x16 to x23, never written
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000
// x24 to x31, never written
00000000 00000000 00000000 00000000 00000000 00000000 00000000 00000000

// ==== files.f ====
source/core_cfg_pkg.sv
source/rv_isa_pkg.sv
source/decode_bus_if.sv
source/fetch_unit.sv
source/reg_file.sv
source/decode_unit.sv
source/execute_unit.sv
source/core_top.sv
verification/core_monitor.sv
verification/core_checker.sv
verification/core_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the core testbench with Verilator, run it, and judge the log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module core_tb \
    -f files.f -o core_sim > build.log 2>&1 \
    && ./obj_dir/core_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -qx "Finished with no errors" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
